// File: run.sh
#!/usr/bin/env bash
# build with Verilator and run; the exit status follows the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module rename_tb -o rename_sim \
    && ./obj_dir/rename_sim | tee /dev/stderr | grep -qF '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/rename_tb.sv
`default_nettype none

module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rename_pkg::*;

    localparam int max_instr = 120;  // upper bound over all tests

    typedef struct {
        logic [6:0]  s1, s2, dst;
        logic [31:0] op1, op2;
        logic        r1, r2;
        logic [11:0] imm;
        logic        is_imm;
    } pkt_t;

    logic clk, reset, in_valid, in_ready, out_valid, out_ready, rel_en;
    rv_instr_u in_instr;
    logic wb_add_en, wb_load_en, wb_mul_en, wb_div_en;
    logic [6:0] wb_add_idx, wb_load_idx, wb_mul_idx, wb_div_idx, rel_idx;
    logic [31:0] wb_add_data, wb_load_data, wb_mul_data, wb_div_data;
    logic [6:0] out_src1_phys, out_src2_phys, out_dst_phys;
    logic [31:0] out_op1, out_op2;
    logic out_ready1, out_ready2, out_is_imm;
    logic [11:0] out_imm;

    // reference state
    logic [6:0]  mmap [32];
    logic [6:0]  mfree [$];
    logic [31:0] mval [128];
    logic        mvalid [128];
    pkt_t        expq [$];
    pkt_t        e;
    logic [31:0] lfsr = 32'hf39079b4;
    int          errors = 0;
    int          checks = 0;
    int          rd;

    rename_stage_top #(.num_phys(128), .num_arch(32)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((max_instr * 4 + 100) * 100);
        $display("timeout: the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // one step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rv_instr_u r_word(input int rdx, input int rs1, input int rs2);
        rv_instr_u w;
        w.r = '{7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rdx), opcode_op};
        return w;
    endfunction

    function automatic rv_instr_u i_word(input int rdx, input int rs1, input int imm);
        rv_instr_u w;
        w.i = '{12'(imm), 5'(rs1), 3'd0, 5'(rdx), opcode_op_imm};
        return w;
    endfunction

    // expected packet for an accepted word, updates map and free list
    function automatic pkt_t model_issue(input rv_instr_u w);
        pkt_t p;
        p.is_imm = (w.i.opcode == opcode_op_imm);
        p.s1     = mmap[w.r.rs1];
        p.s2     = p.is_imm ? 7'd0 : mmap[w.r.rs2];
        p.op1    = mval[p.s1];
        p.r1     = mvalid[p.s1];
        p.op2    = mval[p.s2];
        p.r2     = mvalid[p.s2];
        p.imm    = p.is_imm ? w.i.imm12 : 12'd0;
        p.dst    = 7'd0;
        if (w.r.rd != 0) begin
            p.dst = mfree.pop_front();
            mmap[w.r.rd] = p.dst;
            mvalid[p.dst] = 1'b0;
        end
        return p;
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic issue(input rv_instr_u w);
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= w;
        do @(negedge clk); while (!in_ready);
        @(posedge clk);  // accept edge
        expq.push_back(model_issue(w));
        in_valid <= 1'b0;
    endtask

    // same index on every port in the mask, port p writes base + p
    task automatic write_back(input logic [3:0] ports, input int idx, input logic [31:0] base);
        @(posedge clk);
        {wb_div_en, wb_mul_en, wb_load_en, wb_add_en} <= ports;
        {wb_add_idx, wb_load_idx, wb_mul_idx, wb_div_idx} <= {4{7'(idx)}};
        wb_add_data  <= base;
        wb_load_data <= base + 1;
        wb_mul_data  <= base + 2;
        wb_div_data  <= base + 3;
        @(posedge clk);
        {wb_div_en, wb_mul_en, wb_load_en, wb_add_en} <= 4'b0;
        for (int p = 0; p < 4; p++) begin
            if (ports[p] && idx != 0) begin  // div-most port ends up last
                mval[idx] = base + p;
                mvalid[idx] = 1'b1;
            end
        end
    endtask

    task automatic release_reg(input int idx);
        @(posedge clk);
        rel_en  <= 1'b1;
        rel_idx <= 7'(idx);
        @(posedge clk);
        rel_en <= 1'b0;
        mfree.push_back(7'(idx));
    endtask

    task automatic test_done(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // compare every output handshake
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (expq.size() == 0) begin
                errors++;
                $display("packet at %0t came out with no instruction accepted", $time);
            end else begin
                e = expq.pop_front();
                expect_eq("src1", 32'(out_src1_phys), 32'(e.s1));
                expect_eq("src2", 32'(out_src2_phys), 32'(e.s2));
                expect_eq("dst", 32'(out_dst_phys), 32'(e.dst));
                expect_eq("imm", 32'(out_imm), 32'(e.imm));
                expect_eq("is_imm", 32'(out_is_imm), 32'(e.is_imm));
                expect_eq("ready1", 32'(out_ready1), 32'(e.r1 | mvalid[e.s1]));  // late wb forwards
                expect_eq("ready2", 32'(out_ready2), 32'(e.r2 | mvalid[e.s2]));
                if (e.r1 | mvalid[e.s1]) expect_eq("op1", out_op1, e.r1 ? e.op1 : mval[e.s1]);
                if (e.r2 | mvalid[e.s2]) expect_eq("op2", out_op2, e.r2 ? e.op2 : mval[e.s2]);
            end
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        out_ready = 1'b1;
        rel_en = 1'b0;
        rel_idx = '0;
        {wb_add_en, wb_load_en, wb_mul_en, wb_div_en} = 4'b0;
        {wb_add_idx, wb_load_idx, wb_mul_idx, wb_div_idx} = '0;
        {wb_add_data, wb_load_data, wb_mul_data, wb_div_data} = '0;
        for (int a = 0; a < 32; a++) mmap[a] = 7'(a);
        for (int r = 0; r < 128; r++) begin
            mval[r] = (r < 32) ? 32'(r) : 32'd0;
            mvalid[r] = (r < 32);
        end
        for (int r = 32; r < 128; r++) mfree.push_back(7'(r));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 1; i < 32; i++) begin  // rd equal to rs1 reads the old mapping
            issue(r_word(i, i, (i + 1) % 32));
            @(negedge clk);
            expect_eq("allocation order", 32'(out_dst_phys), 32'(31 + i));
        end
        test_done("reset state");

        issue(r_word(5, 1, 2));
        issue(r_word(6, 5, 0));
        @(negedge clk);
        expect_eq("dependent ready", 32'(out_ready1), 32'd0);
        write_back(4'b0001, mmap[5], 32'h2000_0000);
        issue(r_word(7, 5, 5));
        @(negedge clk);
        expect_eq("written operand", out_op1, 32'h2000_0000);
        test_done("dependence");

        @(posedge clk);
        out_ready <= 1'b0;
        issue(r_word(11, 9, 10));
        repeat (2) @(negedge clk);
        expect_eq("held ready1", 32'(out_ready1), 32'd0);
        write_back(4'b0010, mmap[9], 32'h3000_0000);
        write_back(4'b0100, mmap[10], 32'h3100_0000);
        @(negedge clk);
        expect_eq("forwarded op1", out_op1, 32'h3000_0001);
        expect_eq("forwarded op2", out_op2, 32'h3100_0002);
        expect_eq("in_ready while held", 32'(in_ready), 32'd0);
        @(posedge clk);
        out_ready <= 1'b1;
        test_done("back-pressure forwarding");

        issue(i_word(0, 3, 12'h5a3));
        @(negedge clk);
        expect_eq("I-type is_imm", 32'(out_is_imm), 32'd1);
        expect_eq("I-type imm", 32'(out_imm), 32'h5a3);
        expect_eq("I-type src2", 32'(out_src2_phys), 32'd0);
        expect_eq("x0 destination", 32'(out_dst_phys), 32'd0);
        issue(r_word(0, 4, 8));
        issue(i_word(12, 12, 12'hfff));
        test_done("I-type decode");

        while (mfree.size() > 0) begin
            rd = 1 + rand_bits(5) % 31;
            if (rand_bits(1)) issue(i_word(rd, rand_bits(5), rand_bits(12)));
            else issue(r_word(rd, rand_bits(5), rand_bits(5)));
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= r_word(3, 1, 2);
        repeat (3) begin
            @(negedge clk);
            expect_eq("in_ready with empty free list", 32'(in_ready), 32'd0);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        release_reg(45);
        release_reg(38);
        issue(r_word(4, 1, 2));
        @(negedge clk);
        expect_eq("first released dst", 32'(out_dst_phys), 32'd45);
        issue(r_word(7, 1, 2));
        @(negedge clk);
        expect_eq("second released dst", 32'(out_dst_phys), 32'd38);
        test_done("free list exhaustion");

        write_back(4'b1001, mmap[7], 32'h6000_0000);
        issue(r_word(0, 7, 0));
        @(negedge clk);
        expect_eq("writeback priority", out_op1, 32'h6000_0003);
        test_done("writeback priority");

        while (expq.size() != 0) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/rename_pkg.sv
verilog/phys_reg_file.sv
verilog/rename_map.sv
verilog/operand_collect.sv
verilog/rename_stage_top.sv
test/rename_tb.sv

// File: verilog/operand_collect.sv
`default_nettype none

module operand_collect #(
    parameter int num_phys = 128
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          take,
    input  logic [$clog2(num_phys)-1:0]   src1_phys,
    input  logic [$clog2(num_phys)-1:0]   src2_phys,
    input  logic [$clog2(num_phys)-1:0]   dst_phys,
    input  logic [rename_pkg::imm_w-1:0]  imm,
    input  logic                          is_imm,
    input  logic [rename_pkg::xlen-1:0]   rd_data1,
    input  logic [rename_pkg::xlen-1:0]   rd_data2,
    input  logic                          rd_valid1,
    input  logic                          rd_valid2,
    input  logic                          wb_add_en,
    input  logic [$clog2(num_phys)-1:0]   wb_add_idx,
    input  logic [rename_pkg::xlen-1:0]   wb_add_data,
    input  logic                          wb_load_en,
    input  logic [$clog2(num_phys)-1:0]   wb_load_idx,
    input  logic [rename_pkg::xlen-1:0]   wb_load_data,
    input  logic                          wb_mul_en,
    input  logic [$clog2(num_phys)-1:0]   wb_mul_idx,
    input  logic [rename_pkg::xlen-1:0]   wb_mul_data,
    input  logic                          wb_div_en,
    input  logic [$clog2(num_phys)-1:0]   wb_div_idx,
    input  logic [rename_pkg::xlen-1:0]   wb_div_data,
    input  logic                          out_ready,
    output logic                          hold,
    output logic                          out_valid,
    output logic [$clog2(num_phys)-1:0]   out_src1_phys,
    output logic [$clog2(num_phys)-1:0]   out_src2_phys,
    output logic [$clog2(num_phys)-1:0]   out_dst_phys,
    output logic [rename_pkg::xlen-1:0]   out_op1,
    output logic [rename_pkg::xlen-1:0]   out_op2,
    output logic                          out_ready1,
    output logic                          out_ready2,
    output logic [rename_pkg::imm_w-1:0]  out_imm,
    output logic                          out_is_imm
);

    import rename_pkg::*;

    localparam int pw = $clog2(num_phys);

    logic            fresh;  // first cycle after a load, operands come from the file
    logic [xlen-1:0] op_q  [2];
    logic [1:0]      rdy_q;
    logic [xlen:0]   cur   [2];  // {ready, value}
    logic [xlen:0]   nxt   [2];
    logic [pw-1:0]   held_src [2];

    logic            wb_en   [4];
    logic [pw-1:0]   wb_idx  [4];
    logic [xlen-1:0] wb_data [4];

    assign wb_en   = '{wb_add_en, wb_load_en, wb_mul_en, wb_div_en};
    assign wb_idx  = '{wb_add_idx, wb_load_idx, wb_mul_idx, wb_div_idx};
    assign wb_data = '{wb_add_data, wb_load_data, wb_mul_data, wb_div_data};

    function automatic logic [xlen:0] fwd(input logic [pw-1:0] idx, input logic [xlen:0] now);
        logic [xlen:0] r;
        r = now;
        for (int p = 0; p < 4; p++) begin
            if (wb_en[p] && wb_idx[p] == idx && idx != '0) begin
                r = {1'b1, wb_data[p]};  // div-most match wins
            end
        end
        return r;
    endfunction

    assign hold     = out_valid && !out_ready;
    assign held_src = '{out_src1_phys, out_src2_phys};

    assign cur[0] = fresh ? {rd_valid1, rd_data1} : {rdy_q[0], op_q[0]};
    assign cur[1] = fresh ? {rd_valid2, rd_data2} : {rdy_q[1], op_q[1]};
    assign {out_ready1, out_op1} = cur[0];
    assign {out_ready2, out_op2} = cur[1];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            nxt[k] = fwd(held_src[k], cur[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            fresh     <= 1'b0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;  // drained
            end
            fresh <= take;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (take) begin
            out_src1_phys <= src1_phys;
            out_src2_phys <= src2_phys;
            out_dst_phys  <= dst_phys;
            out_imm       <= imm;
            out_is_imm    <= is_imm;
        end else if (out_valid) begin
            for (int k = 0; k < 2; k++) begin
                {rdy_q[k], op_q[k]} <= nxt[k];
            end
        end
    end

    a_held_stable: assert property (
        @(posedge clk) disable iff (reset)
        hold |=> out_valid && $stable(out_src1_phys) && $stable(out_src2_phys)
            && $stable(out_dst_phys) && $stable(out_imm) && $stable(out_is_imm)
    );

    // a ready operand stays ready while the consumer stalls
    a_ready_sticky: assert property (
        @(posedge clk) disable iff (reset)
        hold && out_ready1 && out_ready2 |=> out_ready1 && out_ready2
    );

endmodule

`default_nettype wire

// File: verilog/phys_reg_file.sv
`default_nettype none

module phys_reg_file #(
    parameter int num_phys = 128
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [$clog2(num_phys)-1:0]    rd_idx1,
    input  logic [$clog2(num_phys)-1:0]    rd_idx2,
    input  logic                           alloc_en,
    input  logic [$clog2(num_phys)-1:0]    alloc_idx,
    input  logic                           wb_add_en,
    input  logic [$clog2(num_phys)-1:0]    wb_add_idx,
    input  logic [rename_pkg::xlen-1:0]    wb_add_data,
    input  logic                           wb_load_en,
    input  logic [$clog2(num_phys)-1:0]    wb_load_idx,
    input  logic [rename_pkg::xlen-1:0]    wb_load_data,
    input  logic                           wb_mul_en,
    input  logic [$clog2(num_phys)-1:0]    wb_mul_idx,
    input  logic [rename_pkg::xlen-1:0]    wb_mul_data,
    input  logic                           wb_div_en,
    input  logic [$clog2(num_phys)-1:0]    wb_div_idx,
    input  logic [rename_pkg::xlen-1:0]    wb_div_data,
    output logic [rename_pkg::xlen-1:0]    rd_data1,
    output logic [rename_pkg::xlen-1:0]    rd_data2,
    output logic                           rd_valid1,
    output logic                           rd_valid2
);

    import rename_pkg::*;

    localparam int pw       = $clog2(num_phys);
    localparam int num_init = 2 ** arch_idx_w;  // registers that start out valid

    logic [xlen-1:0]     regs [num_phys];
    logic [num_phys-1:0] valid_q;

    // writeback ports in priority order, last one wins
    logic                wb_en   [4];
    logic [pw-1:0]       wb_idx  [4];
    logic [xlen-1:0]     wb_data [4];

    assign wb_en   = '{wb_add_en, wb_load_en, wb_mul_en, wb_div_en};
    assign wb_idx  = '{wb_add_idx, wb_load_idx, wb_mul_idx, wb_div_idx};
    assign wb_data = '{wb_add_data, wb_load_data, wb_mul_data, wb_div_data};

    // value and valid bit as they will stand after this edge
    function automatic logic [xlen:0] read_fwd(input logic [pw-1:0] idx);
        logic [xlen:0] r;
        r = {valid_q[idx], regs[idx]};
        for (int p = 0; p < 4; p++) begin
            if (wb_en[p] && wb_idx[p] == idx && idx != '0) begin
                r = {1'b1, wb_data[p]};
            end
        end
        if (alloc_en && alloc_idx == idx && idx != '0) begin
            r[xlen] = 1'b0;  // fresh destination, clear wins
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < num_phys; r++) begin
                regs[r]    <= (r < num_init) ? xlen'(r) : '0;
                valid_q[r] <= (r < num_init);
            end
        end else begin
            for (int p = 0; p < 4; p++) begin
                if (wb_en[p] && wb_idx[p] != '0) begin  // reg 0 stays zero
                    regs[wb_idx[p]]    <= wb_data[p];
                    valid_q[wb_idx[p]] <= 1'b1;
                end
            end
            if (alloc_en && alloc_idx != '0) begin
                valid_q[alloc_idx] <= 1'b0;
            end
        end
    end

    // registered read ports
    always_ff @(posedge clk) begin
        {rd_valid1, rd_data1} <= read_fwd(rd_idx1);
        {rd_valid2, rd_data2} <= read_fwd(rd_idx2);
    end

    // the map must never hand out the hardwired zero register
    a_no_alloc_zero: assert property (
        @(posedge clk) disable iff (reset)
        alloc_en |-> alloc_idx != '0
    );

endmodule

`default_nettype wire

// File: verilog/rename_map.sv
`default_nettype none

module rename_map #(
    parameter int num_phys = 128,
    parameter int num_arch = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  rename_pkg::rv_instr_u         in_instr,
    output logic                          in_ready,
    input  logic                          hold,
    input  logic                          rel_en,
    input  logic [$clog2(num_phys)-1:0]   rel_idx,
    output logic                          take,
    output logic [$clog2(num_phys)-1:0]   src1_phys,
    output logic [$clog2(num_phys)-1:0]   src2_phys,
    output logic [$clog2(num_phys)-1:0]   dst_phys,
    output logic [rename_pkg::imm_w-1:0]  imm,
    output logic                          is_imm,
    output logic                          alloc_en,
    output logic [$clog2(num_phys)-1:0]   alloc_idx
);

    import rename_pkg::*;

    localparam int pw       = $clog2(num_phys);
    localparam int fl_depth = num_phys - num_arch;
    localparam int ptr_w    = $clog2(fl_depth);
    localparam int cnt_w    = $clog2(fl_depth + 1);

    logic [pw-1:0]    map_q [num_arch];
    logic [pw-1:0]    fl_q  [fl_depth];
    logic [ptr_w-1:0] fl_head;
    logic [ptr_w-1:0] fl_tail;
    logic [cnt_w-1:0] fl_count;

    logic need_dst;
    logic fl_pop;
    logic fl_push;

    // free list depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fl_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // decode
    assign is_imm   = (in_instr.i.opcode == opcode_op_imm);
    assign need_dst = (in_instr.r.rd != '0);  // x0 gets no new register
    assign imm      = is_imm ? in_instr.i.imm12 : '0;

    // lookup uses the map from before this edge
    assign src1_phys = map_q[in_instr.r.rs1];
    assign src2_phys = is_imm ? '0 : map_q[in_instr.r.rs2];  // no rs2 for I-type
    assign alloc_idx = fl_q[fl_head];
    assign dst_phys  = need_dst ? alloc_idx : '0;

    // handshake
    assign in_ready = !hold && !(need_dst && fl_count == '0);
    assign take     = in_valid && in_ready;
    assign alloc_en = take && need_dst;

    assign fl_pop  = alloc_en;
    assign fl_push = rel_en && rel_idx != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < num_arch; a++) begin
                map_q[a] <= pw'(a);  // identity map
            end
            for (int k = 0; k < fl_depth; k++) begin
                fl_q[k] <= pw'(num_arch + k);  // ascending free indices
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= cnt_w'(fl_depth);
        end else begin
            if (alloc_en) begin
                map_q[in_instr.r.rd] <= alloc_idx;
            end
            if (fl_pop) begin
                fl_head <= next_ptr(fl_head);
            end
            if (fl_push) begin
                fl_q[fl_tail] <= rel_idx;
                fl_tail       <= next_ptr(fl_tail);
            end
            case ({fl_push, fl_pop})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;  // none, or both at once
            endcase
        end
    end

    // head and tail must show an entry before one is taken
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        fl_pop |-> (fl_head != fl_tail || fl_count == cnt_w'(fl_depth))
    );

    // a retire into a full list would drop an index
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (fl_push && !fl_pop) |-> fl_count < cnt_w'(fl_depth)
    );

endmodule

`default_nettype wire

// File: verilog/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int arch_idx_w = 5;    // 32 architectural registers
    localparam int phys_idx_w = 7;    // default for 128 physical registers
    localparam int xlen       = 32;
    localparam int imm_w      = 12;

    localparam logic [6:0] opcode_op     = 7'b0110011;  // register-register
    localparam logic [6:0] opcode_op_imm = 7'b0010011;  // register-immediate

    // register-register layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [arch_idx_w-1:0] rs2;
        logic [arch_idx_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [arch_idx_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_r_t;

    // register-immediate layout
    typedef struct packed {
        logic [imm_w-1:0]      imm12;
        logic [arch_idx_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [arch_idx_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_i_t;

    // one word, two views; the opcode picks which one applies
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_instr_u;

endpackage

`default_nettype wire

// File: verilog/rename_stage_top.sv
`default_nettype none

module rename_stage_top #(
    parameter int num_phys = 128,
    parameter int num_arch = 32
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  rename_pkg::rv_instr_u              in_instr,
    output logic                               in_ready,
    input  logic                               wb_add_en,
    input  logic [rename_pkg::phys_idx_w-1:0]  wb_add_idx,
    input  logic [rename_pkg::xlen-1:0]        wb_add_data,
    input  logic                               wb_load_en,
    input  logic [rename_pkg::phys_idx_w-1:0]  wb_load_idx,
    input  logic [rename_pkg::xlen-1:0]        wb_load_data,
    input  logic                               wb_mul_en,
    input  logic [rename_pkg::phys_idx_w-1:0]  wb_mul_idx,
    input  logic [rename_pkg::xlen-1:0]        wb_mul_data,
    input  logic                               wb_div_en,
    input  logic [rename_pkg::phys_idx_w-1:0]  wb_div_idx,
    input  logic [rename_pkg::xlen-1:0]        wb_div_data,
    input  logic                               rel_en,
    input  logic [rename_pkg::phys_idx_w-1:0]  rel_idx,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [rename_pkg::phys_idx_w-1:0]  out_src1_phys,
    output logic [rename_pkg::phys_idx_w-1:0]  out_src2_phys,
    output logic [rename_pkg::phys_idx_w-1:0]  out_dst_phys,
    output logic [rename_pkg::xlen-1:0]        out_op1,
    output logic [rename_pkg::xlen-1:0]        out_op2,
    output logic                               out_ready1,
    output logic                               out_ready2,
    output logic [rename_pkg::imm_w-1:0]       out_imm,
    output logic                               out_is_imm
);

    import rename_pkg::*;

    localparam int pw = $clog2(num_phys);

    logic             take;
    logic             hold;
    logic [pw-1:0]    src1_phys;
    logic [pw-1:0]    src2_phys;
    logic [pw-1:0]    dst_phys;
    logic [imm_w-1:0] imm;
    logic             is_imm;
    logic             alloc_en;
    logic [pw-1:0]    alloc_idx;
    logic [xlen-1:0]  rd_data1;
    logic [xlen-1:0]  rd_data2;
    logic             rd_valid1;
    logic             rd_valid2;

    rename_map #(.num_phys(num_phys), .num_arch(num_arch)) u_map (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_instr(in_instr), .in_ready(in_ready),
        .hold(hold), .rel_en(rel_en), .rel_idx(rel_idx),
        .take(take), .src1_phys(src1_phys), .src2_phys(src2_phys),
        .dst_phys(dst_phys), .imm(imm), .is_imm(is_imm),
        .alloc_en(alloc_en), .alloc_idx(alloc_idx)
    );

    // source indices double as register file read addresses
    phys_reg_file #(.num_phys(num_phys)) u_prf (
        .clk(clk), .reset(reset),
        .rd_idx1(src1_phys), .rd_idx2(src2_phys),
        .alloc_en(alloc_en), .alloc_idx(alloc_idx),
        .wb_add_en(wb_add_en), .wb_add_idx(wb_add_idx), .wb_add_data(wb_add_data),
        .wb_load_en(wb_load_en), .wb_load_idx(wb_load_idx), .wb_load_data(wb_load_data),
        .wb_mul_en(wb_mul_en), .wb_mul_idx(wb_mul_idx), .wb_mul_data(wb_mul_data),
        .wb_div_en(wb_div_en), .wb_div_idx(wb_div_idx), .wb_div_data(wb_div_data),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .rd_valid1(rd_valid1), .rd_valid2(rd_valid2)
    );

    operand_collect #(.num_phys(num_phys)) u_collect (
        .clk(clk), .reset(reset),
        .take(take), .src1_phys(src1_phys), .src2_phys(src2_phys),
        .dst_phys(dst_phys), .imm(imm), .is_imm(is_imm),
        .rd_data1(rd_data1), .rd_data2(rd_data2),
        .rd_valid1(rd_valid1), .rd_valid2(rd_valid2),
        .wb_add_en(wb_add_en), .wb_add_idx(wb_add_idx), .wb_add_data(wb_add_data),
        .wb_load_en(wb_load_en), .wb_load_idx(wb_load_idx), .wb_load_data(wb_load_data),
        .wb_mul_en(wb_mul_en), .wb_mul_idx(wb_mul_idx), .wb_mul_data(wb_mul_data),
        .wb_div_en(wb_div_en), .wb_div_idx(wb_div_idx), .wb_div_data(wb_div_data),
        .out_ready(out_ready), .hold(hold), .out_valid(out_valid),
        .out_src1_phys(out_src1_phys), .out_src2_phys(out_src2_phys),
        .out_dst_phys(out_dst_phys),
        .out_op1(out_op1), .out_op2(out_op2),
        .out_ready1(out_ready1), .out_ready2(out_ready2),
        .out_imm(out_imm), .out_is_imm(out_is_imm)
    );

endmodule

`default_nettype wire
